//--- include/cce_config.svh
// CCE register block widths and counts shared by packages and RTL
`ifndef CCE_CONFIG_SVH
`define CCE_CONFIG_SVH

// Physical address split into tag, set and block offset
`define CCE_PADDR_WIDTH     22
`define CCE_BLOCK_OFFSET    6
`define CCE_SET_BITS        6
`define CCE_TAG_WIDTH       10

// Cache organization
`define CCE_WAY_BITS        3
`define CCE_LCE_ID_BITS     2

// Microcode register file
`define CCE_NUM_GPR         8
`define CCE_GPR_WIDTH       64
`define CCE_IMM_WIDTH       16

// Coherence state, MSHR flags and message fields
`define CCE_COH_BITS        3
`define CCE_NUM_FLAGS       14
`define CCE_NUM_GAD_FLAGS   8
`define CCE_REQ_TYPE_BITS   2
`define CCE_RESP_TYPE_BITS  4

`endif

//--- hw/cce_inst_pkg.sv
// Decoded microcode instruction format and its source selects
`include "cce_config.svh"

package cce_inst_pkg;

  // Source for a single MSHR flag write
  typedef enum logic [1:0] {
    e_flag_src_zero  = 2'd0,
    e_flag_src_logic = 2'd1,
    e_flag_src_imm0  = 2'd2
  } flag_src_e;

  typedef struct packed {
    // GPR write sources
    logic                               alu_w_v;
    logic                               mov_w_v;
    logic                               resp_type_w_v;
    logic                               dir_tag_rd_v;
    logic [`CCE_NUM_GPR-1:0]            gpr_w_mask;

    // MSHR field group enables
    logic                               mshr_clear;
    logic                               req_w_v;
    logic                               way_w_v;
    logic                               lru_way_w_v;
    logic                               owner_w_v;

    // Flag writes
    logic [`CCE_NUM_FLAGS-1:0]          flag_w_mask;
    flag_src_e [`CCE_NUM_FLAGS-1:0]     flag_src;

    // Coherence state writes
    logic                               next_coh_w_v;
    logic                               coh_w_v;

    logic [`CCE_IMM_WIDTH-1:0]          imm;
  } cce_inst_decoded_t;

endpackage

//--- hw/cce_reg_pkg.sv
// Register state types of the CCE microcode unit
`include "cce_config.svh"

package cce_reg_pkg;

  typedef logic [`CCE_GPR_WIDTH-1:0] gpr_t;

  typedef logic [`CCE_RESP_TYPE_BITS-1:0] resp_type_t;

  // MOESIF encoding, 4 and 5 unused
  typedef enum logic [`CCE_COH_BITS-1:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_f = 3'd3,
    e_coh_m = 3'd6,
    e_coh_o = 3'd7
  } coh_state_e;

  // Bit positions within the MSHR flag vector
  typedef enum logic [3:0] {
    e_flag_rqf, e_flag_ucf, e_flag_nerf, e_flag_ldf, e_flag_nwbf,
    e_flag_tf, e_flag_rf, e_flag_uf, e_flag_if, e_flag_cf,
    e_flag_cef, e_flag_cof, e_flag_cdf, e_flag_lef
  } flag_e;

  typedef logic [`CCE_NUM_FLAGS-1:0] flags_t;

  typedef struct packed {
    logic [`CCE_LCE_ID_BITS-1:0]  lce_id;
    logic [`CCE_PADDR_WIDTH-1:0]  paddr;
    logic [`CCE_WAY_BITS-1:0]     way_id;
    logic [`CCE_WAY_BITS-1:0]     lru_way_id;
    logic [`CCE_LCE_ID_BITS-1:0]  owner_lce_id;
    logic [`CCE_WAY_BITS-1:0]     owner_way_id;
    flags_t                       flags;
    coh_state_e                   next_coh_state;
    logic [`CCE_PADDR_WIDTH-1:0]  lru_paddr;
  } mshr_t;

endpackage

//--- hw/cce_if.sv
// LCE request and directory/GAD result bundles inside the register block
`timescale 1ns/1ps
`include "cce_config.svh"

interface cce_lce_req_if;
  logic [`CCE_LCE_ID_BITS-1:0]    src_id;
  logic [`CCE_PADDR_WIDTH-1:0]    addr;
  // 0 read, 1 write, 2 uncached read, 3 uncached write
  logic [`CCE_REQ_TYPE_BITS-1:0]  req_type;
  logic [`CCE_WAY_BITS-1:0]       lru_way;
  logic                           non_excl;
  logic                           lru_dirty;

  modport drv (output src_id, addr, req_type, lru_way, non_excl, lru_dirty);
  modport rcv (input src_id, addr, req_type, lru_way, non_excl, lru_dirty);
endinterface

interface cce_gad_if;
  logic [`CCE_WAY_BITS-1:0]     req_way;
  logic [`CCE_LCE_ID_BITS-1:0]  owner_lce;
  logic [`CCE_WAY_BITS-1:0]     owner_way;
  logic                         transfer;
  logic                         replacement;
  logic                         upgrade;
  logic                         invalidate;
  logic                         cached;
  logic                         cached_excl;
  logic                         cached_owned;
  logic                         cached_dirty;
  // Directory LRU result, valid on its own strobe
  logic                         lru_v;
  logic                         lru_cached_excl;
  logic [`CCE_TAG_WIDTH-1:0]    lru_tag;

  modport drv (output req_way, owner_lce, owner_way, transfer, replacement, upgrade,
               invalidate, cached, cached_excl, cached_owned, cached_dirty,
               lru_v, lru_cached_excl, lru_tag);
  modport rcv (input req_way, owner_lce, owner_way, transfer, replacement, upgrade,
               invalidate, cached, cached_excl, cached_owned, cached_dirty,
               lru_v, lru_cached_excl, lru_tag);
endinterface

//--- hw/cce_gpr_file.sv
// General purpose register file written by masked microcode instructions
`timescale 1ns/1ps
`include "cce_config.svh"

module cce_gpr_file (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      inst_v_i,
  input  cce_inst_pkg::cce_inst_decoded_t           decoded_inst_i,
  input  cce_reg_pkg::gpr_t                         alu_res_i,
  input  cce_reg_pkg::gpr_t                         mov_src_i,
  input  cce_reg_pkg::resp_type_t                   resp_type_i,
  input  logic [`CCE_TAG_WIDTH-1:0]                 dir_tag_i,
  output cce_reg_pkg::gpr_t [`CCE_NUM_GPR-1:0]      gpr_o
);
  import cce_reg_pkg::*;

  gpr_t                     wr_data;
  gpr_t [`CCE_NUM_GPR-1:0]  gpr_r;

  // All masked registers take the same value
  always_comb begin
    if (decoded_inst_i.alu_w_v) begin
      wr_data = alu_res_i;
    end else if (decoded_inst_i.mov_w_v) begin
      wr_data = mov_src_i;
    end else if (decoded_inst_i.resp_type_w_v) begin
      wr_data = gpr_t'(resp_type_i);
    end else if (decoded_inst_i.dir_tag_rd_v) begin
      // Tag goes back to its address position
      wr_data = gpr_t'({dir_tag_i, {(`CCE_PADDR_WIDTH - `CCE_TAG_WIDTH){1'b0}}});
    end else begin
      wr_data = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpr_r <= '0;
    end else if (inst_v_i) begin
      for (int i = 0; i < `CCE_NUM_GPR; i++) begin
        if (decoded_inst_i.gpr_w_mask[i]) begin
          gpr_r[i] <= wr_data;
        end
      end
    end
  end

  assign gpr_o = gpr_r;

endmodule

//--- hw/cce_mshr_flags.sv
// MSHR flag bits with per-flag source select and write mask
`timescale 1ns/1ps
`include "cce_config.svh"

module cce_mshr_flags (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             inst_v_i,
  input  cce_inst_pkg::cce_inst_decoded_t  decoded_inst_i,
  cce_lce_req_if.rcv                       lce_req,
  cce_gad_if.rcv                           gad,
  input  logic                             null_wb_i,
  output cce_reg_pkg::flags_t              flags_o
);
  import cce_inst_pkg::*;
  import cce_reg_pkg::*;

  logic   clear_v;
  flags_t logic_src;
  flags_t flags_n;
  flags_t flags_r;

  assign clear_v = inst_v_i & decoded_inst_i.mshr_clear;

  // Value each flag takes under the logic select
  always_comb begin
    logic_src[e_flag_rqf]  = lce_req.req_type[0];
    // Request types 2 and 3 are the uncached ones
    logic_src[e_flag_ucf]  = lce_req.req_type[1];
    logic_src[e_flag_nerf] = lce_req.non_excl;
    logic_src[e_flag_ldf]  = lce_req.lru_dirty;
    logic_src[e_flag_nwbf] = null_wb_i;
    logic_src[e_flag_tf]   = gad.transfer;
    logic_src[e_flag_rf]   = gad.replacement;
    logic_src[e_flag_uf]   = gad.upgrade;
    logic_src[e_flag_if]   = gad.invalidate;
    logic_src[e_flag_cf]   = gad.cached;
    logic_src[e_flag_cef]  = gad.cached_excl;
    logic_src[e_flag_cof]  = gad.cached_owned;
    logic_src[e_flag_cdf]  = gad.cached_dirty;
    logic_src[e_flag_lef]  = gad.lru_cached_excl;
  end

  always_comb begin
    flags_n = flags_r;
    if (clear_v) begin
      flags_n = '0;
    end else begin
      for (int i = 0; i < `CCE_NUM_FLAGS; i++) begin
        if (inst_v_i && decoded_inst_i.flag_w_mask[i]) begin
          case (decoded_inst_i.flag_src[i])
            e_flag_src_logic: flags_n[i] = logic_src[i];
            e_flag_src_imm0:  flags_n[i] = decoded_inst_i.imm[0];
            default:          flags_n[i] = 1'b0;
          endcase
        end
      end
      // Directory LRU result wins over an instruction write of lef
      if (gad.lru_v) begin
        flags_n[e_flag_lef] = gad.lru_cached_excl;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_r <= '0;
    end else begin
      flags_r <= flags_n;
    end
  end

  assign flags_o = flags_r;

endmodule

//--- hw/cce_mshr.sv
// Miss status holding register with field group writes, clear and LRU address
`timescale 1ns/1ps
`include "cce_config.svh"

module cce_mshr (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             inst_v_i,
  input  cce_inst_pkg::cce_inst_decoded_t  decoded_inst_i,
  input  cce_reg_pkg::coh_state_e          coh_state_i,
  input  logic                             null_wb_i,
  cce_lce_req_if.rcv                       lce_req,
  cce_gad_if.rcv                           gad,
  output cce_reg_pkg::mshr_t               mshr_o
);
  import cce_reg_pkg::*;

  logic                         clear_v;
  logic [`CCE_LCE_ID_BITS-1:0]  lce_id_r;
  logic [`CCE_PADDR_WIDTH-1:0]  paddr_r;
  logic [`CCE_WAY_BITS-1:0]     way_id_r;
  logic [`CCE_WAY_BITS-1:0]     lru_way_id_r;
  logic [`CCE_LCE_ID_BITS-1:0]  owner_lce_id_r;
  logic [`CCE_WAY_BITS-1:0]     owner_way_id_r;
  coh_state_e                   next_coh_r;
  logic [`CCE_PADDR_WIDTH-1:0]  lru_paddr_r;
  flags_t                       flags;

  assign clear_v = inst_v_i & decoded_inst_i.mshr_clear;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_v) begin
      lce_id_r       <= '0;
      paddr_r        <= '0;
      way_id_r       <= '0;
      lru_way_id_r   <= '0;
      owner_lce_id_r <= '0;
      owner_way_id_r <= '0;
      lru_paddr_r    <= '0;
      // A clear keeps the current coherence state for the next transaction
      next_coh_r     <= reset_i ? e_coh_i : coh_state_i;
    end else begin
      if (inst_v_i && decoded_inst_i.req_w_v) begin
        lce_id_r <= lce_req.src_id;
        paddr_r  <= lce_req.addr;
      end
      if (inst_v_i && decoded_inst_i.way_w_v) begin
        way_id_r <= gad.req_way;
      end
      if (inst_v_i && decoded_inst_i.lru_way_w_v) begin
        lru_way_id_r <= lce_req.lru_way;
      end
      if (inst_v_i && decoded_inst_i.owner_w_v) begin
        owner_lce_id_r <= gad.owner_lce;
        owner_way_id_r <= gad.owner_way;
      end
      if (inst_v_i && decoded_inst_i.next_coh_w_v) begin
        next_coh_r <= coh_state_e'(decoded_inst_i.imm[`CCE_COH_BITS-1:0]);
      end
      // LRU victim address in the set of the current request
      if (gad.lru_v) begin
        lru_paddr_r <= {gad.lru_tag, paddr_r[`CCE_BLOCK_OFFSET +: `CCE_SET_BITS],
                        {`CCE_BLOCK_OFFSET{1'b0}}};
      end
    end
  end

  cce_mshr_flags flags_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_v_i       (inst_v_i),
    .decoded_inst_i (decoded_inst_i),
    .lce_req        (lce_req),
    .gad            (gad),
    .null_wb_i      (null_wb_i),
    .flags_o        (flags)
  );

  always_comb begin
    mshr_o.lce_id         = lce_id_r;
    mshr_o.paddr          = paddr_r;
    mshr_o.way_id         = way_id_r;
    mshr_o.lru_way_id     = lru_way_id_r;
    mshr_o.owner_lce_id   = owner_lce_id_r;
    mshr_o.owner_way_id   = owner_way_id_r;
    mshr_o.flags          = flags;
    mshr_o.next_coh_state = next_coh_r;
    mshr_o.lru_paddr      = lru_paddr_r;
  end

endmodule

//--- hw/cce_reg.sv
// CCE microcode register block with GPRs, MSHR and coherence state
`timescale 1ns/1ps
`include "cce_config.svh"

module cce_reg (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   inst_v_i,
  input  cce_inst_pkg::cce_inst_decoded_t        decoded_inst_i,
  input  logic [`CCE_LCE_ID_BITS-1:0]            lce_src_id_i,
  input  logic [`CCE_PADDR_WIDTH-1:0]            lce_addr_i,
  input  logic [`CCE_REQ_TYPE_BITS-1:0]          lce_req_type_i,
  input  logic [`CCE_WAY_BITS-1:0]               lce_lru_way_i,
  input  logic                                   lce_non_excl_i,
  input  logic                                   lce_lru_dirty_i,
  input  logic                                   null_wb_i,
  input  cce_reg_pkg::resp_type_t                resp_type_i,
  input  cce_reg_pkg::gpr_t                      alu_res_i,
  input  cce_reg_pkg::gpr_t                      mov_src_i,
  input  logic [`CCE_WAY_BITS-1:0]               gad_req_way_i,
  input  logic [`CCE_LCE_ID_BITS-1:0]            gad_owner_lce_i,
  input  logic [`CCE_WAY_BITS-1:0]               gad_owner_way_i,
  // Bit 0 transfer up to bit 7 cached dirty
  input  logic [`CCE_NUM_GAD_FLAGS-1:0]          gad_flags_i,
  input  logic [`CCE_TAG_WIDTH-1:0]              dir_tag_i,
  input  logic                                   dir_lru_v_i,
  input  logic                                   dir_lru_cached_excl_i,
  input  logic [`CCE_TAG_WIDTH-1:0]              dir_lru_tag_i,
  output cce_reg_pkg::mshr_t                     mshr_o,
  output cce_reg_pkg::gpr_t [`CCE_NUM_GPR-1:0]   gpr_o,
  output cce_reg_pkg::coh_state_e                coh_state_o
);
  import cce_reg_pkg::*;

  coh_state_e coh_state_r;

  cce_lce_req_if lce_req ();
  cce_gad_if     gad ();

  assign lce_req.src_id    = lce_src_id_i;
  assign lce_req.addr      = lce_addr_i;
  assign lce_req.req_type  = lce_req_type_i;
  assign lce_req.lru_way   = lce_lru_way_i;
  assign lce_req.non_excl  = lce_non_excl_i;
  assign lce_req.lru_dirty = lce_lru_dirty_i;

  assign gad.req_way         = gad_req_way_i;
  assign gad.owner_lce       = gad_owner_lce_i;
  assign gad.owner_way       = gad_owner_way_i;
  assign gad.transfer        = gad_flags_i[0];
  assign gad.replacement     = gad_flags_i[1];
  assign gad.upgrade         = gad_flags_i[2];
  assign gad.invalidate      = gad_flags_i[3];
  assign gad.cached          = gad_flags_i[4];
  assign gad.cached_excl     = gad_flags_i[5];
  assign gad.cached_owned    = gad_flags_i[6];
  assign gad.cached_dirty    = gad_flags_i[7];
  assign gad.lru_v           = dir_lru_v_i;
  assign gad.lru_cached_excl = dir_lru_cached_excl_i;
  assign gad.lru_tag         = dir_lru_tag_i;

  // Coherence state from the move source
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      coh_state_r <= e_coh_i;
    end else if (inst_v_i && decoded_inst_i.coh_w_v) begin
      coh_state_r <= coh_state_e'(mov_src_i[`CCE_COH_BITS-1:0]);
    end
  end

  assign coh_state_o = coh_state_r;

  cce_gpr_file gpr_file_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_v_i       (inst_v_i),
    .decoded_inst_i (decoded_inst_i),
    .alu_res_i      (alu_res_i),
    .mov_src_i      (mov_src_i),
    .resp_type_i    (resp_type_i),
    .dir_tag_i      (dir_tag_i),
    .gpr_o          (gpr_o)
  );

  cce_mshr mshr_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_v_i       (inst_v_i),
    .decoded_inst_i (decoded_inst_i),
    .coh_state_i    (coh_state_r),
    .null_wb_i      (null_wb_i),
    .lce_req        (lce_req),
    .gad            (gad),
    .mshr_o         (mshr_o)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock source with a power-on reset held for a few cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 5
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Released on a falling edge, clear of the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

//--- testbench/cce_reg_asserts.sv
// Concurrent checks on reset, MSHR clear and GPR hold of the CCE register block
`timescale 1ns/1ps
`include "cce_config.svh"

module cce_reg_asserts (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  inst_v_i,
  input  cce_inst_pkg::cce_inst_decoded_t       decoded_inst_i,
  input  cce_reg_pkg::mshr_t                    mshr_i,
  input  cce_reg_pkg::gpr_t [`CCE_NUM_GPR-1:0]  gpr_i,
  input  cce_reg_pkg::coh_state_e               coh_state_i
);
  import cce_reg_pkg::*;

  mshr_t cleared;
  int    fail_count = 0;

  // What a clear leaves behind in the MSHR
  always_comb begin
    cleared = '0;
    cleared.next_coh_state = coh_state_i;
  end

  reset_zero: assert property (@(posedge clk_i)
    reset_i |=> (gpr_i == '0 && mshr_i == '0 && coh_state_i == e_coh_i))
    else begin
      $error("outputs not zero one cycle after reset");
      fail_count++;
    end

  clear_result: assert property (@(posedge clk_i)
    (!reset_i && inst_v_i && decoded_inst_i.mshr_clear) |=> (mshr_i == $past(cleared)))
    else begin
      $error("MSHR does not hold the cleared value after a clear");
      fail_count++;
    end

  gpr_hold: assert property (@(posedge clk_i)
    (!reset_i && !inst_v_i) |=> (gpr_i == $past(gpr_i)))
    else begin
      $error("GPRs changed without a valid instruction");
      fail_count++;
    end

endmodule

bind cce_reg cce_reg_asserts asserts_inst (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .inst_v_i       (inst_v_i),
  .decoded_inst_i (decoded_inst_i),
  .mshr_i         (mshr_o),
  .gpr_i          (gpr_o),
  .coh_state_i    (coh_state_o)
);

//--- testbench/cce_reg_tb.sv
// Table-driven testbench for the CCE register block
`timescale 1ns/1ps
`include "cce_config.svh"

module cce_reg_tb;
  import cce_inst_pkg::*;
  import cce_reg_pkg::*;

  typedef gpr_t [`CCE_NUM_GPR-1:0] gpr_bank_t;

  // Inputs for one cycle and the outputs expected after it
  typedef struct packed {
    logic                           inst_v;
    cce_inst_decoded_t              inst;
    logic [`CCE_PADDR_WIDTH-1:0]    addr;
    logic [`CCE_LCE_ID_BITS-1:0]    src_id;
    logic [`CCE_REQ_TYPE_BITS-1:0]  req_type;
    logic [`CCE_WAY_BITS-1:0]       lru_way;
    logic                           non_excl;
    logic                           lru_dirty;
    logic                           null_wb;
    resp_type_t                     resp_type;
    logic [`CCE_WAY_BITS-1:0]       req_way;
    logic [`CCE_LCE_ID_BITS-1:0]    owner_lce;
    logic [`CCE_WAY_BITS-1:0]       owner_way;
    logic [`CCE_NUM_GAD_FLAGS-1:0]  gad_flags;
    logic [`CCE_TAG_WIDTH-1:0]      dir_tag;
    logic                           lru_cached_excl;
    logic                           lru_v;
    logic [`CCE_TAG_WIDTH-1:0]      lru_tag;
    gpr_t                           alu;
    gpr_t                           mov;
    gpr_bank_t                      exp_gpr;
    mshr_t                          exp_mshr;
    coh_state_e                     exp_coh;
  } row_t;

  logic        clk;
  logic        reset;
  row_t        drv;
  row_t        cur;
  row_t        rows[$];
  gpr_bank_t   model_gpr;
  mshr_t       model_mshr;
  coh_state_e  model_coh;
  gpr_bank_t   gpr;
  mshr_t       mshr;
  coh_state_e  coh_state;
  int          error_count;
  int          check_count;
  int          row_idx;
  int          cycle_count = 0;
  int          timeout_cycles = 0;

  tb_clock_gen clock_gen_inst (
    .clk_o   (clk),
    .reset_o (reset)
  );

  cce_reg cce_reg_inst (
    .clk_i                 (clk),
    .reset_i               (reset),
    .inst_v_i              (drv.inst_v),
    .decoded_inst_i        (drv.inst),
    .lce_src_id_i          (drv.src_id),
    .lce_addr_i            (drv.addr),
    .lce_req_type_i        (drv.req_type),
    .lce_lru_way_i         (drv.lru_way),
    .lce_non_excl_i        (drv.non_excl),
    .lce_lru_dirty_i       (drv.lru_dirty),
    .null_wb_i             (drv.null_wb),
    .resp_type_i           (drv.resp_type),
    .alu_res_i             (drv.alu),
    .mov_src_i             (drv.mov),
    .gad_req_way_i         (drv.req_way),
    .gad_owner_lce_i       (drv.owner_lce),
    .gad_owner_way_i       (drv.owner_way),
    .gad_flags_i           (drv.gad_flags),
    .dir_tag_i             (drv.dir_tag),
    .dir_lru_v_i           (drv.lru_v),
    .dir_lru_cached_excl_i (drv.lru_cached_excl),
    .dir_lru_tag_i         (drv.lru_tag),
    .mshr_o                (mshr),
    .gpr_o                 (gpr),
    .coh_state_o           (coh_state)
  );

  task automatic check_gpr(int idx, gpr_t got, gpr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: gpr_o[%0d] got %h expected %h (row %0d)",
               $time, idx, got, exp, row_idx);
    end
  endtask

  task automatic check_mshr(mshr_t got, mshr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: mshr_o got %h expected %h (row %0d)",
               $time, got, exp, row_idx);
    end
  endtask

  task automatic check_coh(coh_state_e got, coh_state_e exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: coh_state_o got %h expected %h (row %0d)",
               $time, got, exp, row_idx);
    end
  endtask

  task automatic check_outputs(gpr_bank_t exp_gpr, mshr_t exp_mshr, coh_state_e exp_coh);
    for (int i = 0; i < `CCE_NUM_GPR; i++) begin
      check_gpr(i, gpr[i], exp_gpr[i]);
    end
    check_mshr(mshr, exp_mshr);
    check_coh(coh_state, exp_coh);
  endtask

  // Only the six defined encodings
  function automatic coh_state_e pick_coh();
    case ($urandom % 6)
      0: return e_coh_i;
      1: return e_coh_s;
      2: return e_coh_e;
      3: return e_coh_f;
      4: return e_coh_m;
      default: return e_coh_o;
    endcase
  endfunction

  // Random data on every input, all enables off
  task automatic new_row();
    logic [31:0] r;
    cur = '0;
    r = $urandom;
    {cur.addr, cur.src_id, cur.req_type, cur.lru_way, cur.non_excl, cur.lru_dirty,
     cur.null_wb} = r;
    r = $urandom;
    {cur.resp_type, cur.req_way, cur.owner_lce, cur.owner_way, cur.gad_flags, cur.dir_tag,
     cur.lru_cached_excl} = r[30:0];
    r = $urandom;
    cur.lru_tag = r[`CCE_TAG_WIDTH-1:0];
    cur.inst.imm = r[31:16];
    cur.inst.imm[`CCE_COH_BITS-1:0] = pick_coh();
    cur.alu = {$urandom, $urandom};
    cur.mov = {$urandom, $urandom};
    cur.mov[`CCE_COH_BITS-1:0] = pick_coh();
  endtask

  // Reference model step, then the row goes into the table
  task automatic push_row();
    gpr_t                         wr;
    flags_t                       src;
    mshr_t                        nm;
    logic [`CCE_PADDR_WIDTH-1:0]  la;
    nm = model_mshr;
    src = '0;
    src[e_flag_rqf] = cur.req_type[0];
    src[e_flag_ucf] = (cur.req_type == 2'd2) || (cur.req_type == 2'd3);
    src[e_flag_nerf] = cur.non_excl;
    src[e_flag_ldf] = cur.lru_dirty;
    src[e_flag_nwbf] = cur.null_wb;
    src[e_flag_cdf:e_flag_tf] = cur.gad_flags;
    src[e_flag_lef] = cur.lru_cached_excl;
    if (cur.inst_v) begin
      if (cur.inst.alu_w_v) begin
        wr = cur.alu;
      end else if (cur.inst.mov_w_v) begin
        wr = cur.mov;
      end else if (cur.inst.resp_type_w_v) begin
        wr = gpr_t'(cur.resp_type);
      end else if (cur.inst.dir_tag_rd_v) begin
        wr = gpr_t'(cur.dir_tag) << (`CCE_PADDR_WIDTH - `CCE_TAG_WIDTH);
      end else begin
        wr = '0;
      end
      for (int i = 0; i < `CCE_NUM_GPR; i++) begin
        if (cur.inst.gpr_w_mask[i]) begin
          model_gpr[i] = wr;
        end
      end
    end
    if (cur.inst_v && cur.inst.mshr_clear) begin
      nm = '0;
      nm.next_coh_state = model_coh;
    end else begin
      if (cur.inst_v) begin
        if (cur.inst.req_w_v) begin
          nm.lce_id = cur.src_id;
          nm.paddr = cur.addr;
        end
        if (cur.inst.way_w_v) begin
          nm.way_id = cur.req_way;
        end
        if (cur.inst.lru_way_w_v) begin
          nm.lru_way_id = cur.lru_way;
        end
        if (cur.inst.owner_w_v) begin
          nm.owner_lce_id = cur.owner_lce;
          nm.owner_way_id = cur.owner_way;
        end
        for (int f = 0; f < `CCE_NUM_FLAGS; f++) begin
          if (cur.inst.flag_w_mask[f]) begin
            case (cur.inst.flag_src[f])
              e_flag_src_logic: nm.flags[f] = src[f];
              e_flag_src_imm0:  nm.flags[f] = cur.inst.imm[0];
              default:          nm.flags[f] = 1'b0;
            endcase
          end
        end
        if (cur.inst.next_coh_w_v) begin
          nm.next_coh_state = coh_state_e'(cur.inst.imm[`CCE_COH_BITS-1:0]);
        end
      end
      // Victim address keeps the set of the held request
      if (cur.lru_v) begin
        la = model_mshr.paddr;
        la[`CCE_PADDR_WIDTH-1 -: `CCE_TAG_WIDTH] = cur.lru_tag;
        la[`CCE_BLOCK_OFFSET-1:0] = '0;
        nm.lru_paddr = la;
        nm.flags[e_flag_lef] = cur.lru_cached_excl;
      end
    end
    if (cur.inst_v && cur.inst.coh_w_v) begin
      model_coh = coh_state_e'(cur.mov[`CCE_COH_BITS-1:0]);
    end
    model_mshr = nm;
    cur.exp_gpr = model_gpr;
    cur.exp_mshr = model_mshr;
    cur.exp_coh = model_coh;
    rows.push_back(cur);
  endtask

  task automatic gpr_row(logic [3:0] srcs, logic [`CCE_NUM_GPR-1:0] mask);
    new_row();
    cur.inst_v = 1'b1;
    {cur.inst.alu_w_v, cur.inst.mov_w_v, cur.inst.resp_type_w_v, cur.inst.dir_tag_rd_v} = srcs;
    cur.inst.gpr_w_mask = mask;
    push_row();
  endtask

  task automatic mshr_row(logic [3:0] en);
    new_row();
    cur.inst_v = 1'b1;
    {cur.inst.req_w_v, cur.inst.way_w_v, cur.inst.lru_way_w_v, cur.inst.owner_w_v} = en;
    push_row();
  endtask

  task automatic flag_row(logic [`CCE_NUM_FLAGS-1:0] mask, flag_src_e sel, logic imm0);
    new_row();
    cur.inst_v = 1'b1;
    cur.inst.flag_w_mask = mask;
    cur.inst.imm[0] = imm0;
    for (int f = 0; f < `CCE_NUM_FLAGS; f++) begin
      cur.inst.flag_src[f] = sel;
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    // GPR source priority, then no source, then no mask
    gpr_row(4'b1111, 8'hff);
    gpr_row(4'b0111, 8'h0f);
    gpr_row(4'b0011, 8'hf0);
    gpr_row(4'b0001, 8'h3c);
    gpr_row(4'b0000, 8'h81);
    gpr_row(4'b1000, 8'h00);
    // Every enable set but no valid instruction
    new_row();
    cur.inst.alu_w_v = 1'b1;
    cur.inst.gpr_w_mask = 8'hff;
    {cur.inst.req_w_v, cur.inst.way_w_v, cur.inst.lru_way_w_v, cur.inst.owner_w_v} = 4'hf;
    cur.inst.flag_w_mask = '1;
    cur.inst.imm[0] = 1'b1;
    for (int f = 0; f < `CCE_NUM_FLAGS; f++) begin
      cur.inst.flag_src[f] = e_flag_src_imm0;
    end
    cur.inst.next_coh_w_v = 1'b1;
    cur.inst.coh_w_v = 1'b1;
    push_row();
    mshr_row(4'b1000);
    mshr_row(4'b0100);
    mshr_row(4'b0010);
    mshr_row(4'b0001);
    mshr_row(4'b1111);
    // Logic sources across all four request types
    for (int rt = 0; rt < 4; rt++) begin
      flag_row('1, e_flag_src_logic, 1'b0);
      cur.req_type = rt[1:0];
      push_row();
    end
    flag_row('1, e_flag_src_imm0, 1'b1);
    push_row();
    flag_row(14'h0f0f, e_flag_src_zero, 1'b1);
    push_row();
    flag_row(14'h2aa0, e_flag_src_imm0, 1'b0);
    push_row();
    flag_row('0, e_flag_src_logic, 1'b0);
    push_row();
    // Directory LRU result on its own
    repeat (2) begin
      new_row();
      cur.lru_v = 1'b1;
      push_row();
    end
    // Back-to-back coherence writes, then clears
    repeat (4) begin
      new_row();
      cur.inst_v = 1'b1;
      cur.inst.coh_w_v = 1'b1;
      cur.inst.next_coh_w_v = 1'b1;
      push_row();
    end
    new_row();
    cur.inst_v = 1'b1;
    cur.inst.mshr_clear = 1'b1;
    push_row();
    new_row();
    cur.inst_v = 1'b1;
    cur.inst.mshr_clear = 1'b1;
    cur.inst.coh_w_v = 1'b1;
    push_row();
    // Mixed random instructions
    repeat (16) begin
      new_row();
      r = $urandom;
      cur.inst_v = r[0];
      {cur.inst.alu_w_v, cur.inst.mov_w_v, cur.inst.resp_type_w_v,
       cur.inst.dir_tag_rd_v} = r[4:1];
      {cur.inst.req_w_v, cur.inst.way_w_v, cur.inst.lru_way_w_v,
       cur.inst.owner_w_v} = r[8:5];
      {cur.inst.next_coh_w_v, cur.inst.coh_w_v} = r[10:9];
      cur.inst.mshr_clear = (r[13:11] == 3'd0);
      cur.inst.gpr_w_mask = r[21:14];
      r = $urandom;
      cur.inst.flag_w_mask = r[`CCE_NUM_FLAGS-1:0];
      for (int f = 0; f < `CCE_NUM_FLAGS; f++) begin
        case ($urandom % 3)
          0: cur.inst.flag_src[f] = e_flag_src_zero;
          1: cur.inst.flag_src[f] = e_flag_src_logic;
          default: cur.inst.flag_src[f] = e_flag_src_imm0;
        endcase
      end
      push_row();
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h5be));
    drv = '0;
    error_count = 0;
    check_count = 0;
    row_idx = -1;
    model_gpr = '0;
    model_mshr = '0;
    model_coh = e_coh_i;
    build_table();
    timeout_cycles = rows.size() * 3 + 30;
    @(negedge reset);
    check_outputs('0, '0, e_coh_i);
    for (int i = 0; i < rows.size(); i++) begin
      row_idx = i;
      drv = rows[i];
      @(negedge clk);
      check_outputs(rows[i].exp_gpr, rows[i].exp_mshr, rows[i].exp_coh);
    end
    drv = '0;
    error_count += cce_reg_inst.asserts_inst.fail_count;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hw/cce_inst_pkg.sv
hw/cce_reg_pkg.sv
hw/cce_if.sv
hw/cce_gpr_file.sv
hw/cce_mshr_flags.sv
hw/cce_mshr.sv
hw/cce_reg.sv
testbench/tb_clock_gen.sv
testbench/cce_reg_asserts.sv
testbench/cce_reg_tb.sv

//--- Makefile
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = cce_reg_tb
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = all tests passed
SRCS       = $(filter-out +incdir+%,$(shell cat $(FILELIST))) include/cce_config.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
